// ==== common/cam_capture_pkg.sv ====
// ------------------------------------------------
// Shared definitions for the camera capture core
// Address map, widths, register offsets, packer phases
// ------------------------------------------------
package cam_capture_pkg;

	// ------------------------------------------------
	// Widths
	// ------------------------------------------------
	localparam int DATA_W     = 32;	// Bus and pixel word
	localparam int PIXEL_W    = 8;	// One camera byte
	localparam int WB_ADR_W   = 12;	// Word address of the slave
	localparam int PTR_W      = 11;	// Write pointer, four banks deep
	localparam int BANK_ADR_W = 9;	// Word index inside one bank
	localparam int NUM_BANKS  = 4;
	localparam int BANK_SEL_W = 2;	// Upper pointer bits

	// ------------------------------------------------
	// Address map
	// ------------------------------------------------
	// Bit 11 high selects registers, low selects the frame buffer
	localparam int REG_SPACE_BIT = 11;

	localparam logic [PTR_W-1:0] CTRL_REG_OFS = 11'd0;	// Control, read/write
	localparam logic [PTR_W-1:0] STAT_REG_OFS = 11'd1;	// Status, read only

	// ------------------------------------------------
	// Register fields
	// ------------------------------------------------
	localparam int CTRL_CAPTURE_EN_BIT = 0;	// Capture enable
	localparam int STAT_VSYNC_BIT      = 16;	// Live vsync

	// ------------------------------------------------
	// Byte packer phase
	// ------------------------------------------------
	localparam int PACK_PHASE_W = 2;

	localparam logic [PACK_PHASE_W-1:0] EMPTY = 2'd0;	// No byte held
	localparam logic [PACK_PHASE_W-1:0] ONE   = 2'd1;	// One byte held
	localparam logic [PACK_PHASE_W-1:0] TWO   = 2'd2;
	localparam logic [PACK_PHASE_W-1:0] THREE = 2'd3;

	// Next valid byte in this phase completes the word
	localparam logic [PACK_PHASE_W-1:0] PACK_PHASE_LAST = 2'd3;

endpackage

// ==== capture/cam_byte_packer.sv ====
// ------------------------------------------------
// Camera byte qualifier and 4:1 byte packer
// First byte lands in the top byte of the word
// ------------------------------------------------
`timescale 1ns/1ps

module cam_byte_packer
	import cam_capture_pkg::*;
(
	input  logic               WBs_CLK_i,
	input  logic               WBs_RST_i,
	input  logic               capture_en_i,	// From control register
	input  logic               cam_href_i,
	input  logic               cam_vsync_i,
	input  logic [PIXEL_W-1:0] cam_dat_i,
	output logic               word_valid_o,	// One-cycle strobe
	output logic [DATA_W-1:0]  word_data_o
);

	logic                           byte_valid;	// Qualified camera byte
	logic [PACK_PHASE_W-1:0]        phase_q;
	logic [PACK_PHASE_W-1:0]        phase_nxt;
	logic [DATA_W-PIXEL_W-1:0]      acc_q;	// Three leading bytes

	assign byte_valid = cam_href_i & cam_vsync_i;	// Both high

	// ------------------------------------------------
	// Phase sequence
	// ------------------------------------------------
	always_comb begin
		case (phase_q)
			EMPTY:   phase_nxt = ONE;
			ONE:     phase_nxt = TWO;
			TWO:     phase_nxt = THREE;
			THREE:   phase_nxt = EMPTY;	// Word done, start over
			default: phase_nxt = EMPTY;
		endcase
	end

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			phase_q      <= EMPTY;
			word_valid_o <= 1'b0;
		end else if (!capture_en_i) begin
			phase_q      <= EMPTY;	// Drop any partial word
			word_valid_o <= 1'b0;
		end else begin
			word_valid_o <= byte_valid && (phase_q == PACK_PHASE_LAST);
			if (byte_valid) begin
				phase_q <= phase_nxt;	// Gaps hold the phase
			end
		end
	end

	// ------------------------------------------------
	// Byte accumulator and output word
	// ------------------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_valid) begin
			acc_q <= {acc_q[DATA_W-2*PIXEL_W-1:0], cam_dat_i};	// Shift in at bottom
			if (phase_q == PACK_PHASE_LAST) begin
				word_data_o <= {acc_q, cam_dat_i};	// Fourth byte closes word
			end
		end
	end

	// A finished word needs four bytes, so strobes never touch
	assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		word_valid_o |=> !word_valid_o)
		else $error("word_valid_o high in two consecutive cycles");

endmodule

// ==== frame_buffer/frame_bank_ram.sv ====
// ------------------------------------------------
// One 512 x 32 bank
// Synchronous write, registered read
// ------------------------------------------------
`timescale 1ns/1ps

module frame_bank_ram
	import cam_capture_pkg::*;
(
	input  logic                  WBs_CLK_i,
	input  logic                  wr_en_i,
	input  logic [BANK_ADR_W-1:0] wr_adr_i,
	input  logic [DATA_W-1:0]     wr_dat_i,
	input  logic [BANK_ADR_W-1:0] rd_adr_i,
	output logic [DATA_W-1:0]     rd_dat_o	// Valid one cycle after rd_adr_i
);

	logic [DATA_W-1:0] mem [2**BANK_ADR_W];

	// Write port
	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i) begin
			mem[wr_adr_i] <= wr_dat_i;
		end
	end

	// Read port, free running
	always_ff @(posedge WBs_CLK_i) begin
		rd_dat_o <= mem[rd_adr_i];
	end

endmodule

// ==== frame_buffer/frame_buffer.sv ====
// ------------------------------------------------
// Four-bank frame buffer
// Wrapping write pointer, bank write decode, read mux
// ------------------------------------------------
`timescale 1ns/1ps

module frame_buffer
	import cam_capture_pkg::*;
(
	input  logic              WBs_CLK_i,
	input  logic              WBs_RST_i,
	input  logic              word_valid_i,	// Packed word strobe
	input  logic [DATA_W-1:0] word_data_i,
	input  logic [PTR_W-1:0]  rd_adr_i,	// Bank and word index
	output logic [DATA_W-1:0] rd_data_o,	// One cycle after rd_adr_i
	output logic [PTR_W-1:0]  wr_ptr_o
);

	logic [PTR_W-1:0]      wr_ptr_q;
	logic [BANK_SEL_W-1:0] wr_bank;
	logic [BANK_SEL_W-1:0] rd_bank;
	logic [BANK_SEL_W-1:0] rd_bank_q;	// Aligned with RAM output
	logic [NUM_BANKS-1:0]  bank_we;
	logic [DATA_W-1:0]     bank_rd_dat [NUM_BANKS];

	assign wr_bank  = wr_ptr_q[PTR_W-1 -: BANK_SEL_W];	// Bits 10:9
	assign rd_bank  = rd_adr_i[PTR_W-1 -: BANK_SEL_W];
	assign wr_ptr_o = wr_ptr_q;

	// ------------------------------------------------
	// Write pointer
	// ------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wr_ptr_q  <= '0;
			rd_bank_q <= '0;
		end else begin
			rd_bank_q <= rd_bank;
			if (word_valid_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;	// 2047 rolls to 0
			end
		end
	end

	// One enable per bank, only for the bank under the pointer
	always_comb begin
		bank_we = '0;
		bank_we[wr_bank] = word_valid_i;
	end

	// ------------------------------------------------
	// Bank memories
	// ------------------------------------------------
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		frame_bank_ram frame_bank_ram_i (
			.WBs_CLK_i (WBs_CLK_i),
			.wr_en_i   (bank_we[b]),
			.wr_adr_i  (wr_ptr_q[BANK_ADR_W-1:0]),	// Word inside bank
			.wr_dat_i  (word_data_i),
			.rd_adr_i  (rd_adr_i[BANK_ADR_W-1:0]),
			.rd_dat_o  (bank_rd_dat[b])
		);
	end

	// Registered bank select picks the matching RAM output
	assign rd_data_o = bank_rd_dat[rd_bank_q];

	assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$onehot0(bank_we))
		else $error("More than one bank write enable high: %b", bank_we);

endmodule

// ==== design/wb_regs_slave.sv ====
// ------------------------------------------------
// Wishbone classic slave
// Ack, space decode, control register, read mux
// ------------------------------------------------
`timescale 1ns/1ps

module wb_regs_slave
	import cam_capture_pkg::*;
(
	input  logic                WBs_CLK_i,
	input  logic                WBs_RST_i,
	input  logic                wbs_cyc_i,
	input  logic                wbs_stb_i,
	input  logic                wbs_we_i,
	input  logic [WB_ADR_W-1:0] wbs_adr_i,	// Word address
	input  logic [DATA_W-1:0]   wbs_dat_i,
	output logic [DATA_W-1:0]   wbs_dat_o,	// Valid with ack
	output logic                wbs_ack_o,
	input  logic                cam_vsync_i,	// Live, for status
	input  logic [PTR_W-1:0]    wr_ptr_i,
	output logic                capture_en_o,
	output logic [PTR_W-1:0]    frame_rd_adr_o,
	input  logic [DATA_W-1:0]   frame_rd_data_i
);

	logic              req;	// New request, not yet acked
	logic              reg_sel;	// Register space hit
	logic [PTR_W-1:0]  reg_ofs;
	logic              ctrl_wr;
	logic              reg_sel_q;
	logic [PTR_W-1:0]  reg_ofs_q;
	logic [DATA_W-1:0] ctrl_word;
	logic [DATA_W-1:0] stat_word;
	logic [DATA_W-1:0] reg_rd_word;

	// ------------------------------------------------
	// Request decode
	// ------------------------------------------------
	assign req     = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
	assign reg_sel = wbs_adr_i[REG_SPACE_BIT];
	assign reg_ofs = wbs_adr_i[PTR_W-1:0];
	assign ctrl_wr = req & wbs_we_i & reg_sel & (reg_ofs == CTRL_REG_OFS);

	// RAM sees the address in the request cycle, data lines up with ack
	assign frame_rd_adr_o = wbs_adr_i[PTR_W-1:0];

	// ------------------------------------------------
	// Ack and control register
	// ------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wbs_ack_o    <= 1'b0;
			capture_en_o <= 1'b0;
		end else begin
			wbs_ack_o <= req;	// Single-cycle pulse
			if (ctrl_wr) begin
				capture_en_o <= wbs_dat_i[CTRL_CAPTURE_EN_BIT];
			end
		end
	end

	// Remember what was addressed for the ack cycle
	always_ff @(posedge WBs_CLK_i) begin
		if (req) begin
			reg_sel_q <= reg_sel;
			reg_ofs_q <= reg_ofs;
		end
	end

	// ------------------------------------------------
	// Read data
	// ------------------------------------------------
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_CAPTURE_EN_BIT] = capture_en_o;

		stat_word = '0;
		stat_word[PTR_W-1:0]     = wr_ptr_i;	// Bank in 10:9
		stat_word[STAT_VSYNC_BIT] = cam_vsync_i;
	end

	always_comb begin
		case (reg_ofs_q)
			CTRL_REG_OFS: reg_rd_word = ctrl_word;
			STAT_REG_OFS: reg_rd_word = stat_word;
			default:      reg_rd_word = '0;	// Unmapped offset
		endcase
	end

	assign wbs_dat_o = reg_sel_q ? reg_rd_word : frame_rd_data_i;

	// ------------------------------------------------
	// Handshake checks
	// ------------------------------------------------
	assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |=> !wbs_ack_o)
		else $error("wbs_ack_o held for two cycles");

	assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |-> $past(wbs_cyc_i & wbs_stb_i))
		else $error("wbs_ack_o without a preceding request");

endmodule

// ==== design/cam_capture_top.sv ====
// ------------------------------------------------
// Camera capture top level
// Byte packer, frame buffer and Wishbone slave
// ------------------------------------------------
`timescale 1ns/1ps

module cam_capture_top
	import cam_capture_pkg::*;
(
	input  logic                WBs_CLK_i,
	input  logic                WBs_RST_i,
	// Wishbone
	input  logic                wbs_cyc_i,
	input  logic                wbs_stb_i,
	input  logic                wbs_we_i,
	input  logic [WB_ADR_W-1:0] wbs_adr_i,
	input  logic [DATA_W-1:0]   wbs_dat_i,
	output logic [DATA_W-1:0]   wbs_dat_o,
	output logic                wbs_ack_o,
	// Camera, same clock as the bus
	input  logic                cam_href_i,
	input  logic                cam_vsync_i,
	input  logic [PIXEL_W-1:0]  cam_dat_i
);

	logic              capture_en;	// Control bit 0
	logic              word_valid;
	logic [DATA_W-1:0] word_data;
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  frame_rd_adr;
	logic [DATA_W-1:0] frame_rd_data;

	cam_byte_packer cam_byte_packer_i (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.capture_en_i (capture_en),
		.cam_href_i   (cam_href_i),
		.cam_vsync_i  (cam_vsync_i),
		.cam_dat_i    (cam_dat_i),
		.word_valid_o (word_valid),
		.word_data_o  (word_data)
	);

	frame_buffer frame_buffer_i (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.word_valid_i (word_valid),
		.word_data_i  (word_data),
		.rd_adr_i     (frame_rd_adr),
		.rd_data_o    (frame_rd_data),
		.wr_ptr_o     (wr_ptr)
	);

	wb_regs_slave wb_regs_slave_i (
		.WBs_CLK_i       (WBs_CLK_i),
		.WBs_RST_i       (WBs_RST_i),
		.wbs_cyc_i       (wbs_cyc_i),
		.wbs_stb_i       (wbs_stb_i),
		.wbs_we_i        (wbs_we_i),
		.wbs_adr_i       (wbs_adr_i),
		.wbs_dat_i       (wbs_dat_i),
		.wbs_dat_o       (wbs_dat_o),
		.wbs_ack_o       (wbs_ack_o),
		.cam_vsync_i     (cam_vsync_i),	// Status bit 16
		.wr_ptr_i        (wr_ptr),
		.capture_en_o    (capture_en),
		.frame_rd_adr_o  (frame_rd_adr),
		.frame_rd_data_i (frame_rd_data)
	);

endmodule

// ==== dv/cam_capture_tb.sv ====
// ------------------------------------------------
// Testbench for the camera capture top level
// Runs bus and camera commands from the vector file
// Keeps its own packer and frame buffer model
// ------------------------------------------------
`timescale 1ns/1ps

module cam_capture_tb;

	localparam int ACK_TIMEOUT = 16;	// Cycles to wait for ack

	logic        WBs_CLK_i = 1'b0;
	logic        WBs_RST_i;
	logic        wbs_cyc_i;
	logic        wbs_stb_i;
	logic        wbs_we_i;
	logic [11:0] wbs_adr_i;
	logic [31:0] wbs_dat_i;
	logic [31:0] wbs_dat_o;
	logic        wbs_ack_o;
	logic        cam_href_i;
	logic        cam_vsync_i;
	logic [7:0]  cam_dat_i;

	// Reference model of packer and frame buffer
	logic        model_cap_en;
	int          model_phase;	// Bytes held, 0 to 3
	logic [31:0] model_acc;
	logic [10:0] model_ptr;	// Wraps at 2048
	logic [31:0] model_mem [2048];

	integer      seed = 32'h6af1e7b1;
	int          checks;
	int          test_errs;
	int          total_errs;
	int          tests_run;
	int          tests_failed;

	always #2 WBs_CLK_i = ~WBs_CLK_i;	// 4 ns period

	cam_capture_top cam_capture_top_i (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.wbs_cyc_i   (wbs_cyc_i),
		.wbs_stb_i   (wbs_stb_i),
		.wbs_we_i    (wbs_we_i),
		.wbs_adr_i   (wbs_adr_i),
		.wbs_dat_i   (wbs_dat_i),
		.wbs_dat_o   (wbs_dat_o),
		.wbs_ack_o   (wbs_ack_o),
		.cam_href_i  (cam_href_i),
		.cam_vsync_i (cam_vsync_i),
		.cam_dat_i   (cam_dat_i)
	);

	// ------------------------------------------------
	// Helpers
	// ------------------------------------------------
	task automatic note_error();
		test_errs++;
		total_errs++;
	endtask

	task automatic check_word(input string sig, input logic [11:0] adr,
			input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s at address %h: got %h, expected %h", sig, adr, got, exp);
			note_error();
		end
	endtask

	function automatic bit is_space(input byte c);
		return (c == 8'h20) || (c == 8'h09) || (c == 8'h0a) || (c == 8'h0d);
	endfunction

	function automatic string trim_text(input string s);
		int first;
		int last;
		first = 0;
		last  = s.len() - 1;
		while (first <= last && is_space(s.getc(first))) first++;
		while (last >= first && is_space(s.getc(last))) last--;
		if (last < first) return "";
		return s.substr(first, last);
	endfunction

	// One classic cycle, starts and ends on a falling edge
	task automatic bus_access(input logic we, input logic [11:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		waited    = 0;
		rdat      = 'x;
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i  = we;
		wbs_adr_i = adr;
		wbs_dat_i = wdat;
		@(negedge WBs_CLK_i);
		waited = 1;
		while (!wbs_ack_o && waited < ACK_TIMEOUT) begin	// Bounded wait for ack
			@(negedge WBs_CLK_i);
			waited++;
		end
		if (!wbs_ack_o) begin
			$display("Timeout: the slave gave no ack within %0d cycles at address %h",
				ACK_TIMEOUT, adr);
			note_error();
		end else begin
			checks++;
			assert (waited == 1) else begin	// Ack in the cycle after the request
				$display("[ERROR] wbs_ack_o latency: got %h cycles, expected %h", waited, 1);
				note_error();
			end
			rdat = wbs_dat_o;	// Data valid with ack
		end
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
		@(negedge WBs_CLK_i);
		checks++;
		assert (wbs_ack_o === 1'b0) else begin	// Single pulse only
			$display("[ERROR] wbs_ack_o after release: got %h, expected %h", wbs_ack_o, 1'b0);
			note_error();
		end
	endtask

	// Control writes steer the model enable
	task automatic model_write(input logic [11:0] adr, input logic [31:0] dat);
		if (adr == 12'h800) begin
			model_cap_en = dat[0];
			if (!dat[0]) model_phase = 0;	// Partial word dropped
		end
	endtask

	// First byte ends up in the top byte
	task automatic model_byte(input logic [7:0] b, input logic href, input logic vsync);
		if (model_cap_en && href && vsync) begin
			model_acc = {model_acc[23:0], b};
			if (model_phase == 3) begin
				model_mem[model_ptr] = model_acc;
				model_ptr   = model_ptr + 11'd1;
				model_phase = 0;
			end else begin
				model_phase++;
			end
		end
	endtask

	// One camera cycle, href drops afterwards, vsync stays
	task automatic push_byte(input logic [7:0] b, input logic href, input logic vsync);
		cam_dat_i   = b;
		cam_href_i  = href;
		cam_vsync_i = vsync;
		model_byte(b, href, vsync);
		@(negedge WBs_CLK_i);
		cam_href_i = 1'b0;
	endtask

	task automatic push_block(input logic [31:0] words);
		logic [31:0] rnd;
		for (int w = 0; w < int'(words); w++) begin
			for (int b = 0; b < 4; b++) begin
				rnd = $random(seed);
				push_byte(rnd[7:0], 1'b1, 1'b1);	// Back to back bytes
			end
		end
		cam_vsync_i = 1'b0;	// Frame over
	endtask

	// ------------------------------------------------
	// Vector file interpreter
	// ------------------------------------------------
	task automatic run_vectors();
		int          fd;
		int          n;
		string       line;
		string       rest;
		logic [7:0]  cmd;
		logic [31:0] fa;
		logic [31:0] fb;
		logic [31:0] fc;
		logic [31:0] rd_val;
		logic [31:0] exp_val;
		fd = $fopen("dv/cam_capture_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file dv/cam_capture_vectors.txt");
			note_error();
			return;
		end
		while (!$feof(fd)) begin
			n    = $fgets(line, fd);
			line = trim_text(line);
			if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
				cmd  = line.getc(0);
				rest = trim_text(line.substr(1, line.len() - 1));
				fa   = '0;
				fb   = '0;
				fc   = '0;
				n    = $sscanf(rest, "%h %h %h", fa, fb, fc);
				case (cmd)
					"W": begin
						bus_access(1'b1, fa[11:0], fb, rd_val);
						model_write(fa[11:0], fb);
					end
					"R": begin
						bus_access(1'b0, fa[11:0], '0, rd_val);
						check_word("wbs_dat_o", fa[11:0], rd_val, fb);
					end
					"B": push_byte(fa[7:0], fb[0], fc[0]);
					"K": push_block(fa);
					"M": begin	// Frame word against the model
						bus_access(1'b0, fa[11:0], '0, rd_val);
						check_word("wbs_dat_o", fa[11:0], rd_val, model_mem[fa[10:0]]);
					end
					"S": begin	// Status against model pointer and live vsync
						exp_val        = '0;
						exp_val[10:0]  = model_ptr;
						exp_val[16]    = cam_vsync_i;
						bus_access(1'b0, 12'h801, '0, rd_val);
						check_word("wbs_dat_o", 12'h801, rd_val, exp_val);
					end
					"I": repeat (int'(fa)) @(negedge WBs_CLK_i);
					"E": begin
						tests_run++;
						if (test_errs == 0) begin
							$display("test %s: passed", rest);
						end else begin
							$display("test %s: failed with %0d errors", rest, test_errs);
							tests_failed++;
						end
						test_errs = 0;
					end
					default: begin
						$display("Unknown command in the vector file: %s", line);
						note_error();
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------
	// Main sequence
	// ------------------------------------------------
	initial begin
		WBs_RST_i    = 1'b1;
		wbs_cyc_i    = 1'b0;
		wbs_stb_i    = 1'b0;
		wbs_we_i     = 1'b0;
		wbs_adr_i    = '0;
		wbs_dat_i    = '0;
		cam_href_i   = 1'b0;
		cam_vsync_i  = 1'b0;
		cam_dat_i    = '0;
		model_cap_en = 1'b0;
		model_phase  = 0;
		model_acc    = '0;
		model_ptr    = '0;
		checks       = 0;
		test_errs    = 0;
		total_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < 2048; i++) model_mem[i] = '0;
		repeat (5) @(negedge WBs_CLK_i);	// Reset for 5 cycles
		WBs_RST_i = 1'b0;
		@(negedge WBs_CLK_i);
		run_vectors();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, total_errs);
		if (total_errs == 0 && tests_run > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== dv/cam_capture_vectors.txt ====
# Columns: command letter, then hex fields
# W adr dat | R adr exp | B byte href vsync | K words | M adr | S | I cycles | E name
R 801 00000000
R 800 00000000
E after_reset
B aa 1 1
B bb 1 1
B cc 1 1
B dd 1 1
I 3
R 801 00010000
B 00 0 0
W 010 deadbeef
R 805 00000000
S
E capture_disabled
W 800 00000001
R 800 00000001
B 11 1 1
I 2
B 55 0 1
B 22 1 1
B 66 1 0
I 1
B 33 1 1
B 77 0 0
B 44 1 1
B 00 0 0
I 3
R 000 11223344
R 801 00000001
E packing_order
B 01 1 1
B 02 1 1
W 800 00000000
W 800 00000001
B a1 1 1
B a2 1 1
B a3 1 1
B a4 1 1
B 00 0 0
I 3
R 001 a1a2a3a4
R 801 00000002
E dropped_partial
K 834
I 3
M 000
M 035
M 036
M 1ff
M 200
M 3ff
M 400
M 5ab
M 7ff
R 801 00000036
S
E bank_wrap
B 00 0 1
I 1
R 801 00010036
S
B 00 0 0
R 801 00000036
S
E vsync_status

// ==== vlog.f ====
common/cam_capture_pkg.sv
capture/cam_byte_packer.sv
frame_buffer/frame_bank_ram.sv
frame_buffer/frame_buffer.sv
design/wb_regs_slave.sv
design/cam_capture_top.sv
dv/cam_capture_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the camera capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f \
	--top-module cam_capture_tb \
	-Mdir "$BUILD_DIR" \
	-o cam_capture_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/cam_capture_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
	exit 0
else
	echo "Simulation did not pass, see $LOG"
	exit 1
fi
